/* hdl/fpAluPkg.sv */
package fpAluPkg;

    // operand widths
    localparam int DATA_WIDTH   = 64;
    localparam int SINGLE_WIDTH = 32;

    // exponent widths, used to find NaN encodings
    localparam int SINGLE_EXP = 8;
    localparam int DOUBLE_EXP = 11;

    typedef logic [DATA_WIDTH-1:0]   data_t;    // operand and result word
    typedef logic [SINGLE_WIDTH-1:0] single_t;  // single precision word
    typedef logic [31:0]             inst_t;
    typedef logic [6:0]              seqNo_t;
    typedef logic [6:0]              phyDest_t;
    typedef logic [5:0]              alId_t;    // active list index

    // instruction field positions
    localparam int OPCODE_LO = 0;
    localparam int OPCODE_HI = 6;
    localparam int FN3_LO    = 12;
    localparam int FN3_HI    = 14;
    localparam int FMT_LO    = 25;
    localparam int FMT_HI    = 26;
    localparam int FN5_LO    = 27;
    localparam int FN5_HI    = 31;

    localparam logic [6:0] OP_FP = 7'b1010011;

    localparam logic [1:0] FMT_S = 2'b00;
    localparam logic [1:0] FMT_D = 2'b01;

    // fn5 groups
    localparam logic [4:0] FN5_FSGNJ    = 5'b00100;
    localparam logic [4:0] FN5_FMIN_MAX = 5'b00101;
    localparam logic [4:0] FN5_FCOMP    = 5'b10100;
    localparam logic [4:0] FN5_FMV_FP2I = 5'b11100;
    localparam logic [4:0] FN5_FMV_I2FP = 5'b11110;

    // fn3 selects inside each fn5 group
    localparam logic [2:0] FN3_FSGNJ  = 3'b000;
    localparam logic [2:0] FN3_FSGNJN = 3'b001;
    localparam logic [2:0] FN3_FSGNJX = 3'b010;
    localparam logic [2:0] FN3_FMIN   = 3'b000;
    localparam logic [2:0] FN3_FMAX   = 3'b001;
    localparam logic [2:0] FN3_FEQ    = 3'b010;
    localparam logic [2:0] FN3_FLT    = 3'b001;
    localparam logic [2:0] FN3_FLE    = 3'b000;
    localparam logic [2:0] FN3_FMV    = 3'b000;
    localparam logic [2:0] FN3_FCLASS = 3'b001;

    typedef struct packed {
        logic        valid;
        seqNo_t      seqNo;
        logic [31:0] pc;
        phyDest_t    phyDest;
        logic        phyDestValid;
        alId_t       alId;
        inst_t       inst;
    } exePkt_t;

    typedef struct packed {
        logic        valid;
        seqNo_t      seqNo;
        logic [31:0] pc;
        phyDest_t    phyDest;
        alId_t       alId;
        logic        destValid;
        logic        executed;
        data_t       destData;
    } wbPkt_t;

    typedef struct packed {
        logic singleLt;
        logic singleEq;
        logic doubleLt;
        logic doubleEq;
    } cmpRes_t;

    // single results sit zero-extended in the low word
    typedef struct packed {
        data_t singleSgnj;
        data_t singleSgnjn;
        data_t singleSgnjx;
        data_t doubleSgnj;
        data_t doubleSgnjn;
        data_t doubleSgnjx;
    } sgnRes_t;

endpackage

/* hdl/fpCompare.sv */
`timescale 1ns/1ps

module fpCompare (
    input  logic              clk_i,
    input  fpAluPkg::data_t   a_i,
    input  fpAluPkg::data_t   b_i,
    output fpAluPkg::cmpRes_t cmp_o
);

    logic [1:0] lt;  // index 0 is single, 1 is double
    logic [1:0] eq;

    // same ordering logic for both formats, only the field widths differ
    for (genvar f = 0; f < 2; f++)
    begin : gFmt
        localparam int W = (f == 0) ? fpAluPkg::SINGLE_WIDTH : fpAluPkg::DATA_WIDTH;
        localparam int E = (f == 0) ? fpAluPkg::SINGLE_EXP : fpAluPkg::DOUBLE_EXP;
        localparam int M = W - E - 1;

        logic         aSign;
        logic         bSign;
        logic [E-1:0] aExp;
        logic [E-1:0] bExp;
        logic [M-1:0] aMan;
        logic [M-1:0] bMan;
        logic [W-2:0] aMag;
        logic [W-2:0] bMag;
        logic         aNan;
        logic         bNan;
        logic         aZero;
        logic         bZero;
        logic         unordered;
        logic         bothZero;
        logic         magLt;

        assign aSign = a_i[W-1];
        assign bSign = b_i[W-1];
        assign aExp  = a_i[W-2 -: E];
        assign bExp  = b_i[W-2 -: E];
        assign aMan  = a_i[M-1:0];
        assign bMan  = b_i[M-1:0];
        assign aMag  = a_i[W-2:0];  // exponent and mantissa order like an unsigned int
        assign bMag  = b_i[W-2:0];

        assign aNan  = (&aExp) & (|aMan);
        assign bNan  = (&bExp) & (|bMan);
        assign aZero = ~|aMag;
        assign bZero = ~|bMag;

        assign unordered = aNan | bNan;
        assign bothZero  = aZero & bZero;  // +0 and -0 compare equal

        // negative values order by larger magnitude first
        assign magLt = aSign ? (aMag > bMag) : (aMag < bMag);

        assign eq[f] = !unordered && (bothZero || (aSign == bSign && aMag == bMag));
        assign lt[f] = !unordered && !bothZero && ((aSign != bSign) ? aSign : magLt);
    end

    assign cmp_o.singleLt = lt[0];
    assign cmp_o.singleEq = eq[0];
    assign cmp_o.doubleLt = lt[1];
    assign cmp_o.doubleEq = eq[1];

    // min/max and FLE downstream rely on lt and eq being exclusive
    assert property (@(posedge clk_i) !(cmp_o.singleEq && cmp_o.singleLt))
        else $error("single compare reports both eq and lt");

    assert property (@(posedge clk_i) !(cmp_o.doubleEq && cmp_o.doubleLt))
        else $error("double compare reports both eq and lt");

endmodule

/* hdl/fpSignInject.sv */
`timescale 1ns/1ps

module fpSignInject (
    input  fpAluPkg::data_t   a_i,
    input  fpAluPkg::data_t   b_i,
    output fpAluPkg::sgnRes_t sgn_o
);

    fpAluPkg::single_t aSingle;
    fpAluPkg::single_t bSingle;
    logic              aSignS;
    logic              bSignS;
    logic              aSignD;
    logic              bSignD;

    assign aSingle = a_i[fpAluPkg::SINGLE_WIDTH-1:0];  // single uses the low word
    assign bSingle = b_i[fpAluPkg::SINGLE_WIDTH-1:0];

    assign aSignS = aSingle[fpAluPkg::SINGLE_WIDTH-1];
    assign bSignS = bSingle[fpAluPkg::SINGLE_WIDTH-1];
    assign aSignD = a_i[fpAluPkg::DATA_WIDTH-1];
    assign bSignD = b_i[fpAluPkg::DATA_WIDTH-1];

    // single results, upper word cleared
    assign sgn_o.singleSgnj  = fpAluPkg::data_t'(
        {bSignS, aSingle[fpAluPkg::SINGLE_WIDTH-2:0]});
    assign sgn_o.singleSgnjn = fpAluPkg::data_t'(
        {~bSignS, aSingle[fpAluPkg::SINGLE_WIDTH-2:0]});
    assign sgn_o.singleSgnjx = fpAluPkg::data_t'(
        {aSignS ^ bSignS, aSingle[fpAluPkg::SINGLE_WIDTH-2:0]});

    assign sgn_o.doubleSgnj  = {bSignD, a_i[fpAluPkg::DATA_WIDTH-2:0]};
    assign sgn_o.doubleSgnjn = {~bSignD, a_i[fpAluPkg::DATA_WIDTH-2:0]};  // negated b sign
    assign sgn_o.doubleSgnjx = {aSignD ^ bSignD, a_i[fpAluPkg::DATA_WIDTH-2:0]};

endmodule

/* hdl/fpResultSelect.sv */
`timescale 1ns/1ps

module fpResultSelect (
    input  logic              clk,
    input  logic              rst_i,
    input  fpAluPkg::exePkt_t exePacket_i,
    input  fpAluPkg::data_t   a_i,
    input  fpAluPkg::data_t   b_i,
    input  fpAluPkg::cmpRes_t cmp_i,
    input  fpAluPkg::sgnRes_t sgn_i,
    output fpAluPkg::wbPkt_t  wbPacket_o
);

    logic [6:0]       opcode;
    logic [1:0]       fmt;
    logic [4:0]       fn5;
    logic [2:0]       fn3;
    logic             isDouble;
    logic             fmtOk;
    logic             lt;
    logic             eq;
    logic             supported;
    logic             executed;
    fpAluPkg::data_t  result;
    fpAluPkg::wbPkt_t wbNext;

    // keeps the low single word for S format, whole word for D
    function automatic fpAluPkg::data_t fitFmt(input fpAluPkg::data_t v, input logic dbl);
        fpAluPkg::single_t low;
        low = v[fpAluPkg::SINGLE_WIDTH-1:0];
        return dbl ? v : fpAluPkg::data_t'(low);
    endfunction

    assign opcode   = exePacket_i.inst[fpAluPkg::OPCODE_HI:fpAluPkg::OPCODE_LO];
    assign fmt      = exePacket_i.inst[fpAluPkg::FMT_HI:fpAluPkg::FMT_LO];
    assign fn5      = exePacket_i.inst[fpAluPkg::FN5_HI:fpAluPkg::FN5_LO];
    assign fn3      = exePacket_i.inst[fpAluPkg::FN3_HI:fpAluPkg::FN3_LO];
    assign isDouble = (fmt == fpAluPkg::FMT_D);
    assign fmtOk    = (fmt == fpAluPkg::FMT_S) || isDouble;

    assign lt = isDouble ? cmp_i.doubleLt : cmp_i.singleLt;
    assign eq = isDouble ? cmp_i.doubleEq : cmp_i.singleEq;

    always_comb
    begin
        supported = 1'b0;
        result    = '0;
        if (opcode == fpAluPkg::OP_FP && fmtOk)
        begin
            case (fn5)
                fpAluPkg::FN5_FSGNJ:
                begin
                    supported = 1'b1;
                    case (fn3)
                        fpAluPkg::FN3_FSGNJ:
                            result = isDouble ? sgn_i.doubleSgnj : sgn_i.singleSgnj;
                        fpAluPkg::FN3_FSGNJN:
                            result = isDouble ? sgn_i.doubleSgnjn : sgn_i.singleSgnjn;
                        fpAluPkg::FN3_FSGNJX:
                            result = isDouble ? sgn_i.doubleSgnjx : sgn_i.singleSgnjx;
                        default:
                            supported = 1'b0;
                    endcase
                end
                fpAluPkg::FN5_FMIN_MAX:
                begin
                    supported = 1'b1;
                    case (fn3)
                        fpAluPkg::FN3_FMIN:
                            result = fitFmt(lt ? a_i : b_i, isDouble);
                        fpAluPkg::FN3_FMAX:
                            result = fitFmt(!lt ? a_i : b_i, isDouble);  // NaN falls back to a
                        default:
                            supported = 1'b0;
                    endcase
                end
                fpAluPkg::FN5_FCOMP:
                begin
                    supported = 1'b1;
                    case (fn3)
                        fpAluPkg::FN3_FEQ:
                            result = fpAluPkg::data_t'(eq);
                        fpAluPkg::FN3_FLT:
                            result = fpAluPkg::data_t'(lt);
                        fpAluPkg::FN3_FLE:
                            result = fpAluPkg::data_t'(eq | lt);
                        default:
                            supported = 1'b0;
                    endcase
                end
                fpAluPkg::FN5_FMV_FP2I:
                begin
                    supported = 1'b1;
                    case (fn3)
                        fpAluPkg::FN3_FMV:
                            result = fitFmt(a_i, isDouble);
                        fpAluPkg::FN3_FCLASS:
                            result = '0;  // class bits not generated
                        default:
                            supported = 1'b0;
                    endcase
                end
                fpAluPkg::FN5_FMV_I2FP:
                begin
                    supported = (fn3 == fpAluPkg::FN3_FMV);
                    result    = fitFmt(a_i, isDouble);
                end
                default:
                    supported = 1'b0;
            endcase
        end
    end

    assign executed = exePacket_i.valid && supported;

    always_comb
    begin
        wbNext.valid     = exePacket_i.valid;
        wbNext.seqNo     = exePacket_i.seqNo;
        wbNext.pc        = exePacket_i.pc;
        wbNext.phyDest   = exePacket_i.phyDest;
        wbNext.alId      = exePacket_i.alId;
        wbNext.executed  = executed;
        wbNext.destValid = executed && exePacket_i.phyDestValid;
        wbNext.destData  = executed ? result : '0;  // unsupported ops write zero
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            wbPacket_o <= '0;
        end
        else
        begin
            wbPacket_o <= wbNext;
        end
    end

    assert property (@(posedge clk) wbPacket_o.executed |-> wbPacket_o.valid)
        else $error("writeback marked executed without valid");

    assert property (@(posedge clk) disable iff (rst_i) !$isunknown(wbPacket_o.valid))
        else $error("writeback valid is unknown after reset");

endmodule

/* hdl/fpAlu.sv */
`timescale 1ns/1ps

module fpAlu (
    input  logic              clk,
    input  logic              rst_i,
    input  fpAluPkg::exePkt_t exePacket_i,
    input  fpAluPkg::data_t   data1_i,
    input  fpAluPkg::data_t   data2_i,
    output fpAluPkg::wbPkt_t  wbPacket_o
);

    fpAluPkg::cmpRes_t cmp;  // compare flags, both formats
    fpAluPkg::sgnRes_t sgn;  // all sign-injection variants

    fpCompare i_compare (
        .clk_i (clk),
        .a_i   (data1_i),
        .b_i   (data2_i),
        .cmp_o (cmp)
    );

    fpSignInject i_signInject (
        .a_i   (data1_i),
        .b_i   (data2_i),
        .sgn_o (sgn)
    );

    // one register stage, so one cycle from exePacket_i to wbPacket_o
    fpResultSelect i_resultSelect (
        .clk         (clk),
        .rst_i       (rst_i),
        .exePacket_i (exePacket_i),
        .a_i         (data1_i),
        .b_i         (data2_i),
        .cmp_i       (cmp),
        .sgn_i       (sgn),
        .wbPacket_o  (wbPacket_o)
    );

endmodule

/* test/fpAluTb.sv */
`timescale 1ns/1ps

module fpAluTb;

    logic              clk;
    logic              rst_i;
    fpAluPkg::exePkt_t exePacket;
    fpAluPkg::data_t   data1;
    fpAluPkg::data_t   data2;
    fpAluPkg::wbPkt_t  wbPacket;
    int                seed;

    // ordering pairs a<b, a>b, -a<b, both negative, equal, +0/-0, NaN a, NaN b
    fpAluPkg::data_t pairD [8][2] = '{
        '{64'h3FF0000000000000, 64'h4000000000000000},
        '{64'h4000000000000000, 64'h3FF0000000000000},
        '{64'hBFF0000000000000, 64'h3FF0000000000000},
        '{64'hC000000000000000, 64'hBFF0000000000000},
        '{64'h3FF0000000000000, 64'h3FF0000000000000},
        '{64'h0000000000000000, 64'h8000000000000000},
        '{64'h7FF8000000000000, 64'h3FF0000000000000},
        '{64'h3FF0000000000000, 64'h7FF8000000000000}
    };
    fpAluPkg::single_t pairS [8][2] = '{
        '{32'h3F800000, 32'h40000000},
        '{32'h40000000, 32'h3F800000},
        '{32'hBF800000, 32'h3F800000},
        '{32'hC0000000, 32'hBF800000},
        '{32'h3F800000, 32'h3F800000},
        '{32'h00000000, 32'h80000000},
        '{32'h7FC00000, 32'h3F800000},
        '{32'h3F800000, 32'h7FC00000}
    };

    fpAlu i_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .exePacket_i (exePacket),
        .data1_i     (data1),
        .data2_i     (data2),
        .wbPacket_o  (wbPacket)
    );

    always #5 clk = ~clk;

    function automatic fpAluPkg::inst_t makeInst(input logic [4:0] fn5, input logic dbl,
                                                 input logic [2:0] fn3);
        logic [1:0] fmt;
        fmt = dbl ? fpAluPkg::FMT_D : fpAluPkg::FMT_S;
        return {fn5, fmt, 5'd2, 5'd1, fn3, 5'd3, fpAluPkg::OP_FP};  // rs2, rs1, rd arbitrary
    endfunction

    function automatic logic isNan(input fpAluPkg::data_t v, input logic dbl);
        return dbl ? (&v[62:52] && |v[51:0]) : (&v[30:23] && |v[22:0]);
    endfunction

    // signed key that follows the float order so +0 and -0 both give 0
    function automatic longint orderKey(input fpAluPkg::data_t v, input logic dbl);
        longint mag;
        mag = 0;
        if (dbl)
            mag[62:0] = v[62:0];
        else
            mag[30:0] = v[30:0];
        return (dbl ? v[63] : v[31]) ? -mag : mag;
    endfunction

    function automatic logic lessThan(input fpAluPkg::data_t a, input fpAluPkg::data_t b,
                                      input logic dbl);
        return !isNan(a, dbl) && !isNan(b, dbl) && (orderKey(a, dbl) < orderKey(b, dbl));
    endfunction

    function automatic logic equalValue(input fpAluPkg::data_t a, input fpAluPkg::data_t b,
                                        input logic dbl);
        return !isNan(a, dbl) && !isNan(b, dbl) && (orderKey(a, dbl) == orderKey(b, dbl));
    endfunction

    function automatic fpAluPkg::data_t lowWord(input fpAluPkg::data_t v, input logic dbl);
        return dbl ? v : {32'h0, v[31:0]};  // single results are zero-extended
    endfunction

    task automatic checkValue(input string name, input fpAluPkg::data_t expected,
                              input fpAluPkg::data_t actual);
        if (actual !== expected)
        begin
            $display("Fail %s: expected %h actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic drivePacket(input fpAluPkg::inst_t inst, input fpAluPkg::data_t a,
                               input fpAluPkg::data_t b, input logic vld);
        exePacket.valid        = vld;
        exePacket.seqNo        = fpAluPkg::seqNo_t'($urandom);
        exePacket.pc           = $urandom;
        exePacket.phyDest      = fpAluPkg::phyDest_t'($urandom);
        exePacket.phyDestValid = $urandom % 2;
        exePacket.alId         = fpAluPkg::alId_t'($urandom);
        exePacket.inst         = inst;
        data1                  = a;
        data2                  = b;
    endtask

    task automatic verifyWriteback(input string name, input fpAluPkg::exePkt_t sent,
                                   input logic expExec, input fpAluPkg::data_t expData);
        checkValue({name, " valid"}, sent.valid, wbPacket.valid);
        checkValue({name, " seqNo"}, sent.seqNo, wbPacket.seqNo);
        checkValue({name, " pc"}, sent.pc, wbPacket.pc);
        checkValue({name, " phyDest"}, sent.phyDest, wbPacket.phyDest);
        checkValue({name, " alId"}, sent.alId, wbPacket.alId);
        checkValue({name, " executed"}, expExec, wbPacket.executed);
        checkValue({name, " destValid"}, expExec & sent.phyDestValid, wbPacket.destValid);
        checkValue({name, " destData"}, expData, wbPacket.destData);
    endtask

    // one packet in and its result one cycle later
    task automatic runOp(input string name, input fpAluPkg::inst_t inst,
                         input fpAluPkg::data_t a, input fpAluPkg::data_t b,
                         input logic expExec, input fpAluPkg::data_t expData);
        fpAluPkg::exePkt_t sent;
        drivePacket(inst, a, b, 1'b1);
        sent = exePacket;
        @(posedge clk);
        #1;
        verifyWriteback(name, sent, expExec, expData);
    endtask

    task automatic afterReset();
        checkValue("reset valid", 1'b0, wbPacket.valid);
        checkValue("reset executed", 1'b0, wbPacket.executed);
        checkValue("reset destValid", 1'b0, wbPacket.destValid);
    endtask

    task automatic idleDrop();
        int cycles;
        drivePacket(makeInst(fpAluPkg::FN5_FSGNJ, 1'b1, fpAluPkg::FN3_FSGNJ),
                    {$urandom, $urandom}, {$urandom, $urandom}, 1'b1);
        @(posedge clk);
        #1;
        checkValue("idle prior valid", 1'b1, wbPacket.valid);
        drivePacket(exePacket.inst, data1, data2, 1'b0);
        cycles = 0;
        do
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 8)
            begin
                $display("timeout: writeback valid never dropped after an idle packet");
                $display("*** FAILED ***");
                $fatal(1, "timeout");
            end
        end
        while (wbPacket.valid !== 1'b0);
        checkValue("idle latency", 1, cycles);
        checkValue("idle executed", 1'b0, wbPacket.executed);
        checkValue("idle destValid", 1'b0, wbPacket.destValid);
    endtask

    task automatic signInjection();
        fpAluPkg::data_t a;
        fpAluPkg::data_t b;
        fpAluPkg::data_t exp;
        logic            dbl;
        int              sb;
        for (int i = 0; i < 8; i++)
        begin
            a     = {$urandom, $urandom};
            b     = {$urandom, $urandom};
            a[63] = i[1];  // walk through all sign combinations
            a[31] = i[1];
            b[63] = i[2];
            b[31] = i[2];
            dbl   = i[0];
            sb    = dbl ? 63 : 31;
            exp     = lowWord(a, dbl);
            exp[sb] = b[sb];
            runOp("fsgnj", makeInst(fpAluPkg::FN5_FSGNJ, dbl, fpAluPkg::FN3_FSGNJ),
                  a, b, 1'b1, exp);
            exp[sb] = ~b[sb];
            runOp("fsgnjn", makeInst(fpAluPkg::FN5_FSGNJ, dbl, fpAluPkg::FN3_FSGNJN),
                  a, b, 1'b1, exp);
            exp[sb] = a[sb] ^ b[sb];
            runOp("fsgnjx", makeInst(fpAluPkg::FN5_FSGNJ, dbl, fpAluPkg::FN3_FSGNJX),
                  a, b, 1'b1, exp);
        end
    endtask

    task automatic minMaxCompare();
        fpAluPkg::data_t a;
        fpAluPkg::data_t b;
        logic            dbl;
        logic            lt;
        logic            eq;
        for (int f = 0; f < 2; f++)
        begin
            for (int i = 0; i < 8; i++)
            begin
                dbl = f[0];
                a   = dbl ? pairD[i][0] : {$urandom, pairS[i][0]};  // junk in upper word
                b   = dbl ? pairD[i][1] : {$urandom, pairS[i][1]};
                lt  = lessThan(a, b, dbl);
                eq  = equalValue(a, b, dbl);
                runOp("fmin", makeInst(fpAluPkg::FN5_FMIN_MAX, dbl, fpAluPkg::FN3_FMIN),
                      a, b, 1'b1, lowWord(lt ? a : b, dbl));
                runOp("fmax", makeInst(fpAluPkg::FN5_FMIN_MAX, dbl, fpAluPkg::FN3_FMAX),
                      a, b, 1'b1, lowWord(!lt ? a : b, dbl));
                runOp("feq", makeInst(fpAluPkg::FN5_FCOMP, dbl, fpAluPkg::FN3_FEQ),
                      a, b, 1'b1, eq);
                runOp("flt", makeInst(fpAluPkg::FN5_FCOMP, dbl, fpAluPkg::FN3_FLT),
                      a, b, 1'b1, lt);
                runOp("fle", makeInst(fpAluPkg::FN5_FCOMP, dbl, fpAluPkg::FN3_FLE),
                      a, b, 1'b1, eq | lt);
            end
        end
    endtask

    task automatic moveAndClass();
        fpAluPkg::data_t a;
        fpAluPkg::data_t b;
        logic            dbl;
        for (int i = 0; i < 6; i++)
        begin
            a   = {$urandom, $urandom};
            b   = {$urandom, $urandom};
            dbl = i[0];
            runOp("fmv fp2i", makeInst(fpAluPkg::FN5_FMV_FP2I, dbl, fpAluPkg::FN3_FMV),
                  a, b, 1'b1, lowWord(a, dbl));
            runOp("fmv i2fp", makeInst(fpAluPkg::FN5_FMV_I2FP, dbl, fpAluPkg::FN3_FMV),
                  a, b, 1'b1, lowWord(a, dbl));
            runOp("fclass", makeInst(fpAluPkg::FN5_FMV_FP2I, dbl, fpAluPkg::FN3_FCLASS),
                  a, b, 1'b1, '0);
        end
    endtask

    task automatic backToBack();
        fpAluPkg::exePkt_t first;
        fpAluPkg::exePkt_t second;
        fpAluPkg::data_t   a;
        fpAluPkg::data_t   b;
        fpAluPkg::inst_t   badInst;
        a = {$urandom, $urandom};
        b = {$urandom, $urandom};
        drivePacket(makeInst(fpAluPkg::FN5_FSGNJ, 1'b1, fpAluPkg::FN3_FSGNJX), a, b, 1'b1);
        first = exePacket;
        @(posedge clk);
        #1;
        drivePacket(makeInst(fpAluPkg::FN5_FMV_FP2I, 1'b1, fpAluPkg::FN3_FMV), b, a, 1'b1);
        second = exePacket;
        verifyWriteback("back-to-back first", first, 1'b1, {a[63] ^ b[63], a[62:0]});
        @(posedge clk);
        #1;
        verifyWriteback("back-to-back second", second, 1'b1, b);
        badInst      = makeInst(fpAluPkg::FN5_FSGNJ, 1'b1, fpAluPkg::FN3_FSGNJ);
        badInst[6:0] = 7'b0110011;  // integer OP opcode
        runOp("bad opcode", badInst, a, b, 1'b0, '0);
        runOp("bad fn5", makeInst(5'b00011, 1'b1, 3'b000), a, b, 1'b0, '0);  // fdiv is dropped
    endtask

    initial
    begin
        seed = 99;
        void'($urandom(seed));
        clk             = 1'b0;
        rst_i           = 1'b1;
        data1           = '0;
        data2           = '0;
        exePacket       = '0;
        exePacket.valid = 1'b1;  // a live packet that reset must hold off
        exePacket.inst  = makeInst(fpAluPkg::FN5_FSGNJ, 1'b1, fpAluPkg::FN3_FSGNJ);
        repeat (4) @(posedge clk);
        #1;
        afterReset();
        rst_i = 1'b0;
        idleDrop();
        signInjection();
        minMaxCompare();
        moveAndClass();
        backToBack();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* flist.f */
hdl/fpAluPkg.sv
hdl/fpCompare.sv
hdl/fpSignInject.sv
hdl/fpResultSelect.sv
hdl/fpAlu.sv
test/fpAluTb.sv

/* Bender.yml */
package:
  name: fpAlu

sources:
  - hdl/fpAluPkg.sv
  - hdl/fpCompare.sv
  - hdl/fpSignInject.sv
  - hdl/fpResultSelect.sv
  - hdl/fpAlu.sv
  - target: test
    files:
      - test/fpAluTb.sv
